/* include/boot_cfg.svh */
`ifndef BOOT_CFG_SVH
`define BOOT_CFG_SVH

// Number of 16-bit words copied from flash at boot.
// This must be a power of two so the write index wraps cleanly after the last word.
`define BOOT_IMAGE_WORDS 64

// Width of a word address into the instruction store.
`define IMEM_ADDR_W 6

// Flash byte address that holds word 0 of the image.
`define FLASH_BASE_ADDR 24'h100000

// Each RAM bank holds one half of the image.
`define BANK_WORDS (`BOOT_IMAGE_WORDS / 2)

// The top address bit picks the bank, so a bank index is one bit narrower.
`define BANK_ADDR_W (`IMEM_ADDR_W - 1)

`endif

/* hw/flash_pkg.sv */
`default_nettype none

package flash_pkg;

  // Standard serial NOR read command.
  localparam logic [7:0] FLASH_OP_READ = 8'h03;

  typedef struct packed {
    logic [7:0]  opcode;
    logic [23:0] addr;      // Byte address, sent high byte first.
  } flash_cmd_fields_t;

  // The command header is built as fields and sent as bytes.
  // Index 3 of the byte view is the opcode, so bytes go out from 3 down to 0.
  typedef union packed {
    flash_cmd_fields_t f;
    logic [3:0][7:0]   bytes;
  } flash_cmd_u;

  // Byte phases of one READ transaction in the order they go on the wire.
  typedef enum logic [2:0] {
    CMD,
    ADDR_HI,
    ADDR_MID,
    ADDR_LO,
    DUMMY,
    DATA_HI,
    DATA_LO
  } reader_phase_e;

endpackage

`default_nettype wire

/* hw/imem_pkg.sv */
`default_nettype none

`include "boot_cfg.svh"

package imem_pkg;

  localparam int INSTR_W = 16;

  // One instruction word as stored in flash and in the RAM banks.
  typedef logic [INSTR_W-1:0] instr_t;

  // Word address into the store.
  // The top bit selects the bank and the rest index a word inside it.
  typedef logic [`IMEM_ADDR_W-1:0] iaddr_t;

endpackage

`default_nettype wire

/* hw/spi_flash_reader.sv */
`default_nettype none
`timescale 1ns/1ps

module spi_flash_reader (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             rd_en,
  input  logic [23:0]      byte_addr,
  output imem_pkg::instr_t word,
  output logic             word_valid,
  output logic             spi_cs,
  output logic             spi_sclk,
  output logic             spi_mosi,
  input  logic             spi_miso
);
  import flash_pkg::*;

  flash_cmd_u    cmd;
  reader_phase_e phase;
  logic          busy;       // High from chip select low until the last data byte is in.
  logic          valid_q;
  logic [3:0]    bit_cnt;
  logic [7:0]    shreg;      // Outgoing bits leave at bit 7 and incoming bits enter at bit 0.
  logic [7:0]    tx_next;
  logic          start;
  logic          shift_in;
  logic          step;

  assign cmd.f = '{opcode: FLASH_OP_READ, addr: byte_addr};

  // Byte to load at the setup cycle that follows the current phase.
  always_comb begin
    case (phase)
      CMD:      tx_next = cmd.bytes[2];
      ADDR_HI:  tx_next = cmd.bytes[1];
      ADDR_MID: tx_next = cmd.bytes[0];
      default:  tx_next = 8'h00;          // Dummy and data bytes send zeros.
    endcase
  end

  // All progress is frozen while rd_en is low.
  // An idle cycle with valid_q set keeps chip select high between words.
  assign start    = rd_en && !busy && !valid_q;
  assign shift_in = rd_en && busy && (bit_cnt != 4'd0) && !spi_sclk;
  assign step     = rd_en && busy && (bit_cnt == 4'd0);

  assign word_valid = valid_q && rd_en;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      valid_q  <= 1'b0;
      phase    <= CMD;
      bit_cnt  <= 4'd0;
      spi_cs   <= 1'b1;
      spi_sclk <= 1'b1;
      spi_mosi <= 1'b0;
    end else if (rd_en) begin
      if (!busy) begin
        if (valid_q) begin
          valid_q <= 1'b0;                // Word handed over, chip select stays high.
        end else begin
          busy    <= 1'b1;
          spi_cs  <= 1'b0;
          phase   <= CMD;
          bit_cnt <= 4'd8;
        end
      end else if (bit_cnt != 4'd0) begin
        if (spi_sclk) begin
          // Falling edge. The next bit goes out here.
          spi_sclk <= 1'b0;
          spi_mosi <= shreg[7];
        end else begin
          spi_sclk <= 1'b1;               // Rising edge, miso is taken in the payload block.
          bit_cnt  <= bit_cnt - 4'd1;
        end
      end else if (phase == DATA_LO) begin
        busy    <= 1'b0;
        spi_cs  <= 1'b1;
        valid_q <= 1'b1;
      end else begin
        phase   <= reader_phase_e'(phase + 3'd1);
        bit_cnt <= 4'd8;
      end
    end
  end

  // Shift register and the captured word carry data only.
  always_ff @(posedge clk) begin
    if (start) begin
      shreg <= cmd.bytes[3];
    end else if (shift_in) begin
      shreg <= {shreg[6:0], spi_miso};
    end else if (step) begin
      shreg <= tx_next;
    end

    // The dummy byte is never stored. Data arrives high byte first.
    if (step && (phase == DATA_HI)) begin
      word[15:8] <= shreg;
    end
    if (step && (phase == DATA_LO)) begin
      word[7:0] <= shreg;
    end
  end

endmodule

`default_nettype wire

/* hw/imem_bank.sv */
`default_nettype none
`timescale 1ns/1ps

`include "boot_cfg.svh"

module imem_bank (
  input  logic                    clk,
  input  logic                    cs,
  input  logic                    we,
  input  logic [`BANK_ADDR_W-1:0] addr,
  input  imem_pkg::instr_t        wdata,
  output imem_pkg::instr_t        rdata
);
  import imem_pkg::*;

  // Half of the boot image.
  instr_t mem [`BANK_WORDS];

  // A write does not update rdata, as in the single-port RAM this stands for.
  always_ff @(posedge clk) begin
    if (cs) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];     // Read data shows up one cycle after the address.
      end
    end
  end

endmodule

`default_nettype wire

/* hw/boot_rom.sv */
`default_nettype none
`timescale 1ns/1ps

`include "boot_cfg.svh"

module boot_rom (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clken,
  input  imem_pkg::iaddr_t fetch_addr,
  output imem_pkg::instr_t instruction,
  output logic             ready,
  input  logic             spi_miso,
  output logic             spi_cs,
  output logic             spi_sclk,
  output logic             spi_mosi
);
  import imem_pkg::*;

  localparam int SEL_BIT = `IMEM_ADDR_W - 1;

  iaddr_t                  wr_idx;
  logic                    loading;
  logic                    rd_en;
  logic [23:0]             byte_addr;
  instr_t                  word;
  logic                    word_valid;
  logic                    bank_sel;
  logic                    bank_en;
  logic                    sel_q;        // Bank of the read that is in flight.
  logic [`BANK_ADDR_W-1:0] bank_addr;
  instr_t                  rdata_lo;
  instr_t                  rdata_hi;

  assign ready = !loading;
  assign rd_en = loading && clken;

  // Words are two bytes apart in flash.
  assign byte_addr = `FLASH_BASE_ADDR + 24'({wr_idx, 1'b0});

  // The loader owns the banks until the image is in.
  assign bank_sel  = loading ? wr_idx[SEL_BIT] : fetch_addr[SEL_BIT];
  assign bank_addr = loading ? wr_idx[SEL_BIT-1:0] : fetch_addr[SEL_BIT-1:0];
  assign bank_en   = loading ? word_valid : clken;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_idx  <= '0;
      loading <= 1'b1;
    end else if (word_valid) begin
      wr_idx <= wr_idx + 1'b1;        // Wraps to zero after the last word.
      if (wr_idx == '1) begin
        loading <= 1'b0;
      end
    end
  end

  // The bank select is delayed to line up with the registered RAM output.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sel_q <= 1'b0;
    end else if (clken) begin
      sel_q <= bank_sel;
    end
  end

  assign instruction = loading ? '0 : (sel_q ? rdata_hi : rdata_lo);

  spi_flash_reader u_reader (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_en     (rd_en),
    .byte_addr (byte_addr),
    .word      (word),
    .word_valid(word_valid),
    .spi_cs    (spi_cs),
    .spi_sclk  (spi_sclk),
    .spi_mosi  (spi_mosi),
    .spi_miso  (spi_miso)
  );

  imem_bank u_bank_lo (
    .clk  (clk),
    .cs   (bank_en && !bank_sel),
    .we   (word_valid),
    .addr (bank_addr),
    .wdata(word),
    .rdata(rdata_lo)
  );

  imem_bank u_bank_hi (
    .clk  (clk),
    .cs   (bank_en && bank_sel),
    .we   (word_valid),
    .addr (bank_addr),
    .wdata(word),
    .rdata(rdata_hi)
  );

endmodule

`default_nettype wire

/* testbench/spi_flash_model.sv */
`default_nettype none
`timescale 1ns/1ps

module spi_flash_model (
  input  logic spi_cs,
  input  logic spi_sclk,
  input  logic spi_mosi,
  output logic spi_miso
);
  int          bit_cnt = 0;       // Rising sclk edges seen in this transaction.
  logic [31:0] header = '0;       // Opcode and byte address as they came in.
  logic [15:0] data = '0;
  logic [3:0]  data_bit;
  logic        miso_q = 1'b0;

  assign spi_miso = miso_q;

  // Memory contents are a fixed function of the byte address.
  function automatic logic [7:0] flash_byte(input logic [23:0] a);
    logic [23:0] p;
    p = a * 24'd7;
    return p[7:0] ^ 8'h5a;
  endfunction

  // A rising chip select ends the transaction and clears the bit count.
  always @(posedge spi_sclk or posedge spi_cs) begin
    if (spi_cs) begin
      bit_cnt = 0;
    end else begin
      if (bit_cnt < 32) begin
        header = {header[30:0], spi_mosi};
      end
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 32) begin
        // Anything other than READ gets zeros back.
        if (header[31:24] == 8'h03) begin
          data = {flash_byte(header[23:0]), flash_byte(header[23:0] + 24'd1)};
        end else begin
          data = 16'h0000;
        end
      end
    end
  end

  // Each data bit goes out on the falling edge before the rising edge that samples it.
  always @(negedge spi_sclk) begin
    if (!spi_cs && bit_cnt >= 40 && bit_cnt < 56) begin
      data_bit = 4'(55 - bit_cnt);
      miso_q = data[data_bit];
    end
  end

endmodule

`default_nettype wire

/* testbench/fetch_monitor.sv */
`default_nettype none
`timescale 1ns/1ps

`include "boot_cfg.svh"

module fetch_monitor (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clken,
  input  logic             ready,
  input  imem_pkg::iaddr_t fetch_addr,
  input  imem_pkg::instr_t instruction,
  output int unsigned      compares,
  output int unsigned      errors
);
  import imem_pkg::*;

  logic        pend_valid = 1'b0;    // A fetch was taken at the last enabled edge.
  iaddr_t      pend_addr = '0;
  instr_t      exp_word;
  int unsigned compares_q = 0;
  int unsigned errors_q = 0;

  assign compares = compares_q;
  assign errors = errors_q;

  function automatic logic [7:0] flash_byte(input logic [23:0] a);
    logic [23:0] p;
    p = a * 24'd7;
    return p[7:0] ^ 8'h5a;
  endfunction

  // Word i sits big-endian at two bytes per word above the image base.
  function automatic instr_t expected_word(input iaddr_t i);
    logic [23:0] a;
    a = `FLASH_BASE_ADDR + 24'(i) * 24'd2;
    return {flash_byte(a), flash_byte(a + 24'd1)};
  endfunction

  always @(posedge clk) begin
    if (pend_valid) begin
      exp_word = expected_word(pend_addr);
      compares_q <= compares_q + 1;
      if (instruction !== exp_word) begin
        $display("Error: %0d ns instruction expected %h actual %h",
                 $time, exp_word, instruction);
        errors_q <= errors_q + 1;
      end
    end
    if (!rst_n) begin
      pend_valid <= 1'b0;
    end else if (clken) begin
      pend_valid <= ready;               // Data holds while clken is low.
      pend_addr  <= fetch_addr;
    end
  end

endmodule

`default_nettype wire

/* testbench/boot_rom_chk.sv */
`default_nettype none
`timescale 1ns/1ps

module boot_rom_chk (
  input logic             clk,
  input logic             rst_n,
  input logic             ready,
  input logic             spi_cs,
  input logic             spi_sclk,
  input logic             word_valid,
  input imem_pkg::instr_t instruction
);
  int unsigned n_cs = 0;
  int unsigned n_instr = 0;
  int unsigned n_sclk = 0;
  int unsigned n_valid = 0;
  int unsigned fail_count;

  assign fail_count = n_cs + n_instr + n_sclk + n_valid;

  // The flash bus is released for good once the image is in.
  cs_idle_when_ready: assert property (@(posedge clk) disable iff (!rst_n) ready |-> spi_cs)
    else begin
      $error("spi_cs is low while ready is high");
      n_cs = n_cs + 1;
    end

  zero_while_loading: assert property (@(posedge clk) disable iff (!rst_n)
    !ready |-> (instruction == '0))
    else begin
      $error("instruction is not zero while ready is low");
      n_instr = n_instr + 1;
    end

  // Mode 3 keeps the clock high whenever the flash is deselected.
  sclk_idle_high: assert property (@(posedge clk) disable iff (!rst_n) spi_cs |-> spi_sclk)
    else begin
      $error("spi_sclk is low while spi_cs is high");
      n_sclk = n_sclk + 1;
    end

  single_valid: assert property (@(posedge clk) disable iff (!rst_n) word_valid |=> !word_valid)
    else begin
      $error("word_valid is high on two cycles in a row");
      n_valid = n_valid + 1;
    end

endmodule

bind boot_rom boot_rom_chk u_chk (
  .clk        (clk),
  .rst_n      (rst_n),
  .ready      (ready),
  .spi_cs     (spi_cs),
  .spi_sclk   (spi_sclk),
  .word_valid (word_valid),
  .instruction(instruction)
);

`default_nettype wire

/* testbench/boot_rom_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "boot_cfg.svh"

module boot_rom_tb;
  import imem_pkg::*;

  localparam logic [31:0] SEED = 32'h2348;
  localparam int RESET_CYCLES  = 16;
  localparam int START_TIMEOUT = 100;
  localparam int WORD_TIMEOUT  = 2000;
  localparam int LOAD_TIMEOUT  = 40000;

  logic        clk;
  logic        rst_n;
  logic        clken;
  iaddr_t      fetch_addr;
  instr_t      instruction;
  logic        ready;
  logic        spi_miso;
  logic        spi_cs;
  logic        spi_sclk;
  logic        spi_mosi;
  int unsigned mon_compares;
  int unsigned mon_errors;

  int          tb_errors = 0;
  int          tests = 0;
  int          base;           // Error total when the current test began.
  int          n;
  int unsigned cmp_base;
  logic [31:0] rnd;
  logic [2:0]  held;           // spi_cs, spi_sclk and ready when clken went low.
  iaddr_t      prev_addr;

  boot_rom u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .clken      (clken),
    .fetch_addr (fetch_addr),
    .instruction(instruction),
    .ready      (ready),
    .spi_miso   (spi_miso),
    .spi_cs     (spi_cs),
    .spi_sclk   (spi_sclk),
    .spi_mosi   (spi_mosi)
  );

  spi_flash_model u_flash (
    .spi_cs  (spi_cs),
    .spi_sclk(spi_sclk),
    .spi_mosi(spi_mosi),
    .spi_miso(spi_miso)
  );

  fetch_monitor u_mon (
    .clk        (clk),
    .rst_n      (rst_n),
    .clken      (clken),
    .ready      (ready),
    .fetch_addr (fetch_addr),
    .instruction(instruction),
    .compares   (mon_compares),
    .errors     (mon_errors)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int total_errors();
    return tb_errors + int'(mon_errors) + int'(u_dut.u_chk.fail_count);
  endfunction

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected) begin
      $display("Error: %0d ns %s expected %h actual %h", $time, name, expected, actual);
      tb_errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    tb_errors++;
  endtask

  task automatic end_test(input string name);
    tests++;
    if (total_errors() == base) begin
      $display("Test %0d %s: ok", tests, name);
    end else begin
      $display("Test %0d %s: failed with %0d errors", tests, name, total_errors() - base);
    end
  endtask

  // One cycle of the gating pattern, low on every third cycle.
  task automatic gated_step();
    @(negedge clk);
    n++;
    clken = (n % 3) != 0;
  endtask

  initial begin
    rst_n = 1'b0;
    clken = 1'b1;
    fetch_addr = '0;
    rnd = SEED;

    base = total_errors();
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_value("ready", 16'd0, 16'(ready));
      check_value("spi_cs", 16'd1, 16'(spi_cs));
      check_value("spi_sclk", 16'd1, 16'(spi_sclk));
      check_value("instruction", 16'h0000, instruction);
    end
    rst_n = 1'b1;
    @(negedge clk);
    check_value("ready", 16'd0, 16'(ready));
    check_value("instruction", 16'h0000, instruction);
    end_test("reset state");

    base = total_errors();
    n = 0;
    while (spi_cs && n < START_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (spi_cs) begin
      report_timeout("spi_cs did not fall after reset");
    end
    repeat (37) @(negedge clk);        // Lands in the middle of a byte.
    clken = 1'b0;
    held = {spi_cs, spi_sclk, ready};
    repeat (200) begin
      @(negedge clk);
      check_value("spi_cs", 16'(held[2]), 16'(spi_cs));
      check_value("spi_sclk", 16'(held[1]), 16'(spi_sclk));
      check_value("ready", 16'(held[0]), 16'(ready));
    end
    n = 0;
    while (!spi_cs && n < WORD_TIMEOUT) begin
      gated_step();
    end
    if (!spi_cs) begin
      report_timeout("the first word did not complete with clken gated");
    end
    end_test("clken gating");

    base = total_errors();
    n = 0;
    while (!ready && n < LOAD_TIMEOUT) begin
      gated_step();
      if (!ready) begin
        check_value("instruction", 16'h0000, instruction);
      end
      rnd = next_rand(rnd);
      fetch_addr = rnd[`IMEM_ADDR_W-1:0];   // Fetches before ready must read zero.
    end
    if (!ready) begin
      report_timeout("ready did not rise while loading the image");
    end
    clken = 1'b1;
    repeat (50) begin
      @(negedge clk);
      check_value("spi_cs", 16'd1, 16'(spi_cs));
      check_value("spi_sclk", 16'd1, 16'(spi_sclk));
    end
    end_test("load completion");

    base = total_errors();
    cmp_base = mon_compares;
    for (int i = 0; i < `BOOT_IMAGE_WORDS; i++) begin
      @(negedge clk);
      fetch_addr = iaddr_t'(i);
    end
    repeat (2) @(negedge clk);
    if (int'(mon_compares - cmp_base) < `BOOT_IMAGE_WORDS) begin
      $display("The monitor compared fewer sequential fetches than were issued");
      tb_errors++;
    end
    end_test("sequential fetch");

    base = total_errors();
    cmp_base = mon_compares;
    prev_addr = fetch_addr;
    for (int k = 0; k < 200; k++) begin
      @(negedge clk);
      rnd = next_rand(rnd);
      fetch_addr = rnd[`IMEM_ADDR_W-1:0];
      if (k % 2 == 1) begin
        fetch_addr[`IMEM_ADDR_W-1] = ~prev_addr[`IMEM_ADDR_W-1];   // Force a bank switch.
      end
      prev_addr = fetch_addr;
    end
    repeat (2) @(negedge clk);
    if (int'(mon_compares - cmp_base) < 200) begin
      $display("The monitor compared fewer random fetches than were issued");
      tb_errors++;
    end
    end_test("random fetch");

    $display("Tests run: %0d, errors: %0d", tests, total_errors());
    if (total_errors() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
hw/flash_pkg.sv
hw/imem_pkg.sv
hw/spi_flash_reader.sv
hw/imem_bank.sv
hw/boot_rom.sv
testbench/spi_flash_model.sv
testbench/fetch_monitor.sv
testbench/boot_rom_chk.sv
testbench/boot_rom_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module boot_rom_tb -f sources.f

out=$(./obj_dir/Vboot_rom_tb 2>&1)
echo "$out"

if grep -qx "ALL CHECKS PASSED" <<< "$out"; then
  exit 0
else
  exit 1
fi
